/* hw/pit_bus_pkg.sv */
// bus side types of the interval timer: register address, bus byte, control word and strobes
package pit_bus_pkg;

    localparam int NUM_COUNTERS = 3;

    typedef logic [1:0] io_addr_t;                 // 0..2 counters, 3 control register
    typedef logic [7:0] io_byte_t;

    // ************************************************************************
    // control word, written to address 3
    // ************************************************************************
    typedef struct packed {
        logic [1:0] sel;                           // counter select, 3 is read-back
        logic [1:0] rw;                            // access mode, 0 is counter latch
        logic [2:0] mode;                          // counting mode, read-back mask in bits 3..1
        logic       bcd;
    } ctrl_word_t;

    // one-cycle command strobes sent to a single counter
    typedef struct packed {
        logic set_control_mode;
        logic latch_count;
        logic latch_status;
        logic write;
        logic read;
    } cnt_cmd_t;

endpackage

/* hw/pit_count_pkg.sv */
// counting side types of the interval timer: count value, mode and access encodings, status byte
package pit_count_pkg;

    typedef logic [15:0] count_t;

    typedef enum logic [2:0] {
        MODE_INT_TC    = 3'd0,                     // interrupt on terminal count
        MODE_ONESHOT   = 3'd1,                     // hardware retriggerable one-shot
        MODE_RATE      = 3'd2,
        MODE_SQUARE    = 3'd3,
        MODE_SW_STROBE = 3'd4,
        MODE_HW_STROBE = 3'd5
    } pit_mode_t;

    typedef enum logic [1:0] {
        RW_LATCH = 2'd0,
        RW_LSB   = 2'd1,
        RW_MSB   = 2'd2,
        RW_BOTH  = 2'd3                            // lsb first, then msb
    } rw_mode_t;

    // ************************************************************************
    // status byte returned after a read-back with status latching
    // ************************************************************************
    typedef struct packed {
        logic      out;
        logic      null_count;                     // new count written but not yet loaded
        rw_mode_t  rw;
        pit_mode_t mode;
        logic      bcd;
    } status_t;

endpackage

/* hw/pit_clock_div.sv */
// timer clock prescaler, divides clk into the square wave shared by all counters
module pit_clock_div #(
    parameter int CLK_DIV = 4
) (
    input  logic clk,
    input  logic rst_n,
    output logic timer_clk
);

    localparam int CW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic [CW-1:0] div_cnt;

    // half period is CLK_DIV clk cycles
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt   <= '0;
            timer_clk <= 1'b0;
        end else if (div_cnt == CW'(CLK_DIV - 1)) begin
            div_cnt   <= '0;
            timer_clk <= ~timer_clk;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

/* hw/pit_bus_decode.sv */
// bus decoder, turns bus strobes and control or read-back words into per-counter command strobes
module pit_bus_decode
    import pit_bus_pkg::*;
    import pit_count_pkg::*;
(
    input  io_addr_t addr,
    input  logic     wr,
    input  logic     rd,
    input  io_byte_t wdata,
    output cnt_cmd_t cmd [NUM_COUNTERS]
);

    ctrl_word_t ctrl;
    logic       ctrl_wr;
    logic       readback;

    assign ctrl     = wdata;                       // only meaningful on writes to address 3
    assign ctrl_wr  = wr && (addr == 2'd3);
    assign readback = ctrl_wr && (ctrl.sel == 2'd3);

    // ************************************************************************
    // per-counter strobes
    // ************************************************************************
    always_comb begin
        for (int i = 0; i < NUM_COUNTERS; i++) begin
            cmd[i]       = '0;
            cmd[i].write = wr && (addr == io_addr_t'(i));
            cmd[i].read  = rd && (addr == io_addr_t'(i));

            if (readback) begin
                // mask bits 3..1 sit in the mode field, the latch enables are active low
                if (ctrl.mode[i]) begin
                    cmd[i].latch_count  = !ctrl.rw[1];
                    cmd[i].latch_status = !ctrl.rw[0];
                end
            end else if (ctrl_wr && (ctrl.sel == io_addr_t'(i))) begin
                if (ctrl.rw == RW_LATCH) begin
                    cmd[i].latch_count = 1'b1;
                end else begin
                    cmd[i].set_control_mode = 1'b1;
                end
            end
        end
    end

endmodule

/* hw/pit_counter.sv */
// single 8254 style counter with mode logic, count and status latches, binary or bcd decrement
module pit_counter
    import pit_bus_pkg::*;
    import pit_count_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     timer_clk,
    input  logic     gate,
    output logic     out,
    input  io_byte_t wdata,
    input  cnt_cmd_t cmd,
    output io_byte_t rd_byte
);

    ctrl_word_t ctrl;
    pit_mode_t  mode_q;
    rw_mode_t   rw_q;
    logic       bcd_q;
    count_t     load_val;                          // staged lsb/msb count
    count_t     latch_q;
    count_t     count_q;
    count_t     count_dec;
    count_t     sq_reload_at;
    status_t    status_q;
    logic       output_latched, status_latched, status_read;
    logic       null_count, msb_write, msb_read;
    logic       two_byte_write, written, control_set, loaded;
    logic       write_last, write_pulse, read_last, read_pulse, ctrl_last, ctrl_pulse;
    logic       tclk_last, tclk_fall, tclk_rise, gate_last;
    logic       gate_sampled, trigger, trigger_sampled;
    logic       load_cond, en_cond, load, enable;

    assign ctrl = wdata;

    // ************************************************************************
    // programming and access registers
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mode_q <= MODE_RATE;
            rw_q   <= RW_LSB;
            bcd_q  <= 1'b0;
        end else if (cmd.set_control_mode) begin
            // codes 6 and 7 behave as modes 2 and 3
            mode_q <= pit_mode_t'(ctrl.mode[2:1] == 2'b11 ? {1'b0, ctrl.mode[1:0]} : ctrl.mode);
            rw_q   <= rw_mode_t'(ctrl.rw);
            bcd_q  <= ctrl.bcd;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || cmd.set_control_mode) begin
            load_val <= '0;
        end else if (cmd.write) begin
            if (rw_q == RW_LSB || (rw_q == RW_BOTH && !msb_write)) begin
                load_val[7:0] <= wdata;
            end else begin
                load_val[15:8] <= wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!output_latched) latch_q <= count_q;   // follows the count until a latch command
    end

    always_ff @(posedge clk) begin
        if (cmd.latch_status && !status_latched) begin
            status_q <= '{out: out, null_count: null_count, rw: rw_q, mode: mode_q, bcd: bcd_q};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || cmd.set_control_mode) begin
            output_latched <= 1'b0;
            status_latched <= 1'b0;
            null_count     <= !rst_n ? 1'b0 : 1'b1;
            msb_write      <= 1'b0;
            msb_read       <= 1'b0;
            status_read    <= 1'b0;
        end else begin
            if (cmd.latch_count) output_latched <= 1'b1;
            else if (cmd.read && !status_latched && (rw_q != RW_BOTH || msb_read))
                output_latched <= 1'b0;
            if (cmd.latch_status) status_latched <= 1'b1;
            else if (cmd.read) status_latched <= 1'b0;
            if (cmd.read) status_read <= status_latched;    // a status read keeps the byte pointer
            if (cmd.write && (rw_q != RW_BOTH || msb_write)) null_count <= 1'b1;
            else if (load) null_count <= 1'b0;
            if (write_pulse && rw_q == RW_BOTH) msb_write <= ~msb_write;
            if (read_pulse && rw_q == RW_BOTH && !status_read) msb_read <= ~msb_read;
        end
    end

    assign rd_byte = status_latched ? io_byte_t'(status_q) :
                     (rw_q == RW_LSB || (rw_q == RW_BOTH && !msb_read)) ? latch_q[7:0] :
                     latch_q[15:8];

    // ************************************************************************
    // edge detection of strobes, timer clock and gate
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            {write_last, write_pulse, read_last, read_pulse} <= '0;
            {ctrl_last, ctrl_pulse, tclk_last, tclk_fall, gate_last} <= '0;
            {gate_sampled, trigger, trigger_sampled} <= '0;
        end else begin
            write_last  <= cmd.write;
            write_pulse <= write_last && !cmd.write;
            read_last   <= cmd.read;
            read_pulse  <= read_last && !cmd.read;
            ctrl_last   <= cmd.set_control_mode;
            ctrl_pulse  <= ctrl_last && !cmd.set_control_mode;
            tclk_last   <= timer_clk;
            tclk_fall   <= tclk_last && !timer_clk;
            gate_last   <= gate;
            if (tclk_rise) gate_sampled <= gate;
            if (!gate_last && gate) trigger <= 1'b1;   // rising gate arms a trigger
            else if (tclk_rise) trigger <= 1'b0;
            if (tclk_rise) trigger_sampled <= trigger;
        end
    end

    assign tclk_rise = !tclk_last && timer_clk;

    always_ff @(posedge clk) begin
        if (!rst_n || cmd.set_control_mode) begin
            written     <= 1'b0;
            loaded      <= 1'b0;
            control_set <= !rst_n ? 1'b0 : 1'b1;
        end else begin
            if (write_pulse && (rw_q != RW_BOTH || msb_write)) written <= 1'b1;
            else if (load) written <= 1'b0;
            if (load) control_set <= 1'b0;
            if (load) loaded <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) two_byte_write <= 1'b0;
        else if (cmd.write && rw_q == RW_BOTH) two_byte_write <= 1'b1;
        else if (cmd.set_control_mode || load) two_byte_write <= 1'b0;
    end

    // ************************************************************************
    // load and enable per mode
    // ************************************************************************
    assign sq_reload_at = (load_val[0] && out) ? 16'd0 : 16'd2;   // odd counts stretch high half

    always_comb begin
        case (mode_q)
            MODE_INT_TC:    load_cond = written;
            MODE_ONESHOT:   load_cond = trigger_sampled;
            MODE_RATE:      load_cond = (written && control_set) || trigger_sampled ||
                                        (loaded && gate_sampled && count_q == 16'd1);
            MODE_SQUARE:    load_cond = (written && control_set) || trigger_sampled ||
                                        (loaded && gate_sampled && count_q == sq_reload_at);
            MODE_SW_STROBE: load_cond = written;
            default:        load_cond = ((written && control_set) || loaded) && trigger_sampled;
        endcase
        case (mode_q)
            MODE_INT_TC:                  en_cond = gate_sampled && !two_byte_write;
            MODE_ONESHOT, MODE_HW_STROBE: en_cond = 1'b1;
            default:                      en_cond = gate_sampled;
        endcase
    end

    assign load   = tclk_fall && load_cond;
    assign enable = tclk_fall && loaded && !load && en_cond;

    always_comb begin
        if (!bcd_q) count_dec = count_q - 1'b1;
        else if (count_q[15:0] == '0) count_dec = 16'h9999;
        else if (count_q[11:0] == '0) count_dec = {count_q[15:12] - 4'd1, 12'h999};
        else if (count_q[7:0] == '0) count_dec = {count_q[15:8] - 8'd1, 8'h99};
        else if (count_q[3:0] == '0) count_dec = {count_q[15:4] - 12'd1, 4'h9};
        else count_dec = count_q - 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) count_q <= '0;
        else if (load) count_q <= {load_val[15:1], load_val[0] && (mode_q != MODE_SQUARE)};
        else if (enable) count_q <= count_dec - ((mode_q == MODE_SQUARE) ? 16'd1 : 16'd0);
    end

    // ************************************************************************
    // output per mode
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out <= 1'b1;
        end else if (ctrl_pulse) begin
            out <= (mode_q != MODE_INT_TC);
        end else begin
            case (mode_q)
                MODE_INT_TC:    if (load || two_byte_write) out <= 1'b0;
                                else if (count_q == 16'd1 && enable) out <= 1'b1;
                MODE_ONESHOT:   if (load) out <= 1'b0;
                                else if (count_q == 16'd1 && enable) out <= 1'b1;
                MODE_RATE:      if (!gate || load) out <= 1'b1;
                                else if (count_q == 16'd2 && enable) out <= 1'b0;
                MODE_SQUARE:    if (!gate) out <= 1'b1;
                                else if (load && loaded && !trigger_sampled) out <= ~out;
                default:        if (count_q == 16'd1 && enable) out <= 1'b0;   // strobe modes
                                else if (count_q == 16'd0 && enable) out <= 1'b1;
            endcase
        end
    end

endmodule

/* hw/pit_read_port.sv */
// registered read port, returns the addressed counter byte one cycle after rd
module pit_read_port
    import pit_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  io_addr_t addr,
    input  logic     rd,
    input  io_byte_t cnt_byte [NUM_COUNTERS],
    output io_byte_t rdata,
    output logic     rd_valid
);

    io_byte_t sel_byte;

    // the control register is write only and reads back as zero
    assign sel_byte = (addr == 2'd3) ? '0 : cnt_byte[addr];

    always_ff @(posedge clk) begin
        if (rd) rdata <= sel_byte;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd;                        // one cycle pulse per read strobe
        end
    end

endmodule

/* hw/pit_top.sv */
// three channel programmable interval timer on a byte wide bus with a shared prescaled clock
module pit_top
    import pit_bus_pkg::*;
#(
    parameter int CLK_DIV = 4
) (
    input  logic       clk,
    input  logic       rst_n,
    input  io_addr_t   addr,
    input  logic       wr,
    input  logic       rd,
    input  io_byte_t   wdata,
    output io_byte_t   rdata,
    output logic       rd_valid,
    input  logic [2:0] gate,
    output logic [2:0] out
);

    logic     timer_clk;
    cnt_cmd_t cmd      [NUM_COUNTERS];
    io_byte_t cnt_byte [NUM_COUNTERS];

    // ************************************************************************
    // input side
    // ************************************************************************
    pit_clock_div #(.CLK_DIV(CLK_DIV)) u_clock_div (
        .clk       (clk),
        .rst_n     (rst_n),
        .timer_clk (timer_clk)
    );

    pit_bus_decode u_bus_decode (
        .addr  (addr),
        .wr    (wr),
        .rd    (rd),
        .wdata (wdata),
        .cmd   (cmd)
    );

    // ************************************************************************
    // counters
    // ************************************************************************
    pit_counter u_counter0 (
        .clk (clk), .rst_n (rst_n), .timer_clk (timer_clk), .gate (gate[0]),
        .out (out[0]), .wdata (wdata), .cmd (cmd[0]), .rd_byte (cnt_byte[0])
    );

    pit_counter u_counter1 (
        .clk (clk), .rst_n (rst_n), .timer_clk (timer_clk), .gate (gate[1]),
        .out (out[1]), .wdata (wdata), .cmd (cmd[1]), .rd_byte (cnt_byte[1])
    );

    pit_counter u_counter2 (
        .clk (clk), .rst_n (rst_n), .timer_clk (timer_clk), .gate (gate[2]),
        .out (out[2]), .wdata (wdata), .cmd (cmd[2]), .rd_byte (cnt_byte[2])
    );

    // output side
    pit_read_port u_read_port (
        .clk      (clk),
        .rst_n    (rst_n),
        .addr     (addr),
        .rd       (rd),
        .cnt_byte (cnt_byte),
        .rdata    (rdata),
        .rd_valid (rd_valid)
    );

endmodule

/* test/pit_clk_gen.sv */
// testbench clock and reset source, 100 ns clock with reset held low for three cycles
module pit_clk_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #10 rst_n = 1'b1;                          // released at the same offset as the stimulus
    end

endmodule

/* test/pit_props.sv */
// concurrent checks of reset values, gate control and mode 2 output timing of the timer
module pit_props
    import pit_count_pkg::*;
#(
    parameter int CLK_DIV = 4
) (
    input logic       clk,
    input logic       rst_n,
    input logic [1:0] addr,
    input logic       wr,
    input logic       rd_valid,
    input logic [2:0] gate,
    input logic [2:0] out,
    input logic [8:0] modes,                       // one 3-bit mode per counter, counter 0 lowest
    input count_t     load_val0,
    input logic       bcd0
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TPER = 2 * CLK_DIV;             // timer period in clk cycles

    int          fail_count = 0;
    int unsigned since_fall;
    logic        out0_last;
    logic        fell0;
    logic        rose0;
    logic        disturb0;
    logic        fall_seen;                        // clean fall of out[0] since the last disturbance

    assign fell0    = out0_last && !out[0];
    assign rose0    = !out0_last && out[0];
    assign disturb0 = !gate[0] || bcd0 || (modes[2:0] != MODE_RATE) ||
                      (wr && (addr == 2'd0 || addr == 2'd3));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out0_last  <= 1'b1;
            since_fall <= 0;
            fall_seen  <= 1'b0;
        end else begin
            out0_last  <= out[0];
            since_fall <= fell0 ? 1 : since_fall + 1;
            fall_seen  <= !disturb0 && (fall_seen || fell0);
        end
    end

    // ************************************************************************
    // reset state and mode 2 timing of counter 0
    // ************************************************************************
    reset_values: assert property (@(posedge clk) !rst_n |=> (out == 3'b111 && !rd_valid))
        else begin
            fail_count++;
            $error("out or rd_valid not at its reset value");
        end

    rate_low_width: assert property (@(posedge clk) disable iff (!rst_n)
        rose0 && fall_seen |-> int'(since_fall) >= TPER - 1 && int'(since_fall) <= TPER + 1)
        else begin
            fail_count++;
            $error("mode 2 low pulse lasted %0d clk cycles", since_fall);
        end

    rate_period: assert property (@(posedge clk) disable iff (!rst_n)
        fell0 && fall_seen && load_val0 > 16'd1 |->
            int'(since_fall) >= int'(load_val0) * TPER - 1 &&
            int'(since_fall) <= int'(load_val0) * TPER + 1)
        else begin
            fail_count++;
            $error("mode 2 falls %0d clk cycles apart for count %0d", since_fall, load_val0);
        end

    // gate low holds out high in modes 2 and 3
    for (genvar i = 0; i < 3; i++) begin : g_gate
        gate_low_out_high: assert property (@(posedge clk) disable iff (!rst_n)
            (modes[3*i +: 3] inside {MODE_RATE, MODE_SQUARE}) && !gate[i] |=> out[i])
            else begin
                fail_count++;
                $error("counter %0d out not held high while gate is low", i);
            end
    end

endmodule

/* test/pit_tb.sv */
// testbench of the interval timer, drives bus and gates and prints one line per test
module pit_tb
    import pit_bus_pkg::*;
    import pit_count_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_DIV    = 4;
    localparam int DRIVE_DLY  = 10;                // ns after the rising edge
    localparam int WAIT_LIMIT = 50;

    logic       clk, rst_n;
    io_addr_t   addr;
    logic       wr, rd, rd_valid;
    io_byte_t   wdata, rdata;
    logic [2:0] gate, out;
    int         seed;
    int         check_errors, tests_run, tests_failed, errs_before;

    pit_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    pit_top #(.CLK_DIV(CLK_DIV)) u_pit_top (
        .clk(clk), .rst_n(rst_n), .addr(addr), .wr(wr), .rd(rd), .wdata(wdata),
        .rdata(rdata), .rd_valid(rd_valid), .gate(gate), .out(out)
    );

    bind pit_top pit_props #(.CLK_DIV(CLK_DIV)) u_props (
        .clk(clk), .rst_n(rst_n), .addr(addr), .wr(wr), .rd_valid(rd_valid),
        .gate(gate), .out(out), .load_val0(u_counter0.load_val), .bcd0(u_counter0.bcd_q),
        .modes({u_counter2.mode_q, u_counter1.mode_q, u_counter0.mode_q})
    );

    function automatic int total_errors();
        return check_errors + u_pit_top.u_props.fail_count;
    endfunction

    function automatic io_byte_t ctrl_byte(input int sel, input rw_mode_t rw_m,
                                           input pit_mode_t mode, input logic bcd);
        ctrl_word_t cw;
        cw = '{sel: 2'(sel), rw: rw_m, mode: mode, bcd: bcd};
        return cw;
    endfunction

    task automatic abort_run(input string what);
        $display("timeout while waiting for %s", what);
        $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(posedge clk);
        #DRIVE_DLY;
    endtask

    // ************************************************************************
    // bus accesses, four clk cycles each
    // ************************************************************************
    task automatic bus_write(input io_addr_t a, input io_byte_t d);
        addr  = a;
        wdata = d;
        wr    = 1'b1;
        idle(1);
        wr = 1'b0;
        idle(3);
    endtask

    task automatic bus_read(input io_addr_t a, output io_byte_t d);
        int n;
        addr = a;
        rd   = 1'b1;
        idle(1);
        rd = 1'b0;
        n  = 0;
        while (!rd_valid && n < WAIT_LIMIT) begin
            idle(1);
            n++;
        end
        if (!rd_valid) abort_run("rd_valid");
        d = rdata;
        idle(3);
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            check_errors++;
            $display("FAIL %s: expected %0h, got %0h", name, expected, actual);
        end
    endtask

    // latch command, then lsb and msb reads
    task automatic read_latched(input int idx, output count_t value);
        io_byte_t lo, hi;
        bus_write(2'd3, ctrl_byte(idx, RW_LATCH, MODE_INT_TC, 1'b0));
        bus_read(io_addr_t'(idx), lo);
        bus_read(io_addr_t'(idx), hi);
        value = {hi, lo};
    endtask

    task automatic check_status(input int idx, input rw_mode_t rw_m, input pit_mode_t mode,
                                input logic bcd);
        ctrl_word_t rb;
        io_byte_t   got;
        logic [6:0] expected;
        bus_write(2'd3, ctrl_byte(idx, rw_m, mode, bcd));
        rb = '{sel: 2'd3, rw: 2'b10, mode: 3'(1 << idx), bcd: 1'b0};   // status only
        bus_write(2'd3, rb);
        bus_read(io_addr_t'(idx), got);
        expected = {1'b1, rw_m, mode, bcd};        // no count written, so null count is set
        check_value($sformatf("readback_status[%0d]", idx), expected, got[6:0]);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (total_errors() == errs_before) begin
            $display("test %-16s ok", name);
        end else begin
            tests_failed++;
            $display("test %-16s failed", name);
        end
        errs_before = total_errors();
    endtask

    // ************************************************************************
    // test sequence
    // ************************************************************************
    initial begin
        io_byte_t lo;
        count_t   first, second;
        logic     out_last, seen_nine, gate_low_seen;
        int       n, falls;

        addr         = '0;
        wdata        = '0;
        wr           = 1'b0;
        rd           = 1'b0;
        gate         = 3'b111;
        seed         = 32'h0369_76a9;
        check_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        errs_before  = 0;

        n = 0;
        while (rst_n !== 1'b1 && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) abort_run("reset release");
        idle(2);
        end_test("reset_state");

        check_status(0, RW_BOTH, MODE_RATE, 1'b0);
        check_status(1, RW_LSB, MODE_SW_STROBE, 1'b1);
        check_status(2, RW_MSB, MODE_ONESHOT, 1'b0);
        end_test("readback_status");

        bus_write(2'd3, ctrl_byte(0, RW_BOTH, MODE_RATE, 1'b0));
        bus_write(2'd0, 8'h34);
        bus_write(2'd0, 8'h12);
        idle(2 * CLK_DIV + 4);                     // one timer period for the load
        read_latched(0, first);
        read_latched(0, second);
        assert (second <= first && first <= 16'h1234) else begin
            check_errors++;
            $display("FAIL count_latch_running: expected at most %h, got %h", first, second);
        end
        gate[0] = 1'b0;                            // stops the count in mode 2
        idle(4 * CLK_DIV);
        read_latched(0, first);
        read_latched(0, second);
        check_value("count_latch_stopped", first, second);
        gate[0] = 1'b1;
        end_test("count_latch");

        bus_write(2'd3, ctrl_byte(0, RW_LSB, MODE_RATE, 1'b0));
        bus_write(2'd0, 8'd5);
        falls    = 0;
        n        = 0;
        out_last = out[0];
        while (falls < 3 && n < 400) begin
            idle(1);
            if (out_last && !out[0]) falls++;
            out_last = out[0];
            n++;
        end
        if (falls < 3) abort_run("three falling edges of out[0]");
        end_test("rate_generator");

        bus_write(2'd3, ctrl_byte(1, RW_LSB, MODE_RATE, 1'b0));
        bus_write(2'd1, 8'd7);
        bus_write(2'd3, ctrl_byte(2, RW_LSB, MODE_SQUARE, 1'b0));
        bus_write(2'd2, 8'd6);
        gate_low_seen = 1'b0;
        repeat (30) begin
            gate = {2'($random(seed)), 1'b1};      // counter 0 keeps running
            gate_low_seen = gate_low_seen || (gate[2:1] != 2'b11);
            idle(4);
        end
        gate = 3'b111;
        idle(4);
        assert (gate_low_seen) else begin
            check_errors++;
            $display("gate_control: the random gates never went low");
        end
        end_test("gate_control");

        bus_write(2'd3, ctrl_byte(1, RW_LSB, MODE_RATE, 1'b1));
        bus_write(2'd1, 8'h10);
        idle(2 * CLK_DIV + 4);
        seen_nine = 1'b0;
        n         = 0;
        while (!seen_nine && n < 48) begin         // one sample per timer period
            bus_write(2'd3, ctrl_byte(1, RW_LATCH, MODE_INT_TC, 1'b0));
            bus_read(2'd1, lo);
            assert (lo[7:4] <= 4'd9 && lo[3:0] <= 4'd9) else begin
                check_errors++;
                $display("FAIL bcd_count: expected decimal digits, got %h", lo);
            end
            seen_nine = (lo == 8'h09);
            n++;
        end
        assert (seen_nine) else begin
            check_errors++;
            $display("bcd_count: the count never passed through 09");
        end
        end_test("bcd_count");

        $display("tests %0d, failed %0d, check errors %0d, assertion errors %0d",
                 tests_run, tests_failed, check_errors, u_pit_top.u_props.fail_count);
        if (total_errors() == 0 && tests_failed == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
hw/pit_bus_pkg.sv
hw/pit_count_pkg.sv
hw/pit_clock_div.sv
hw/pit_bus_decode.sv
hw/pit_counter.sv
hw/pit_read_port.sv
hw/pit_top.sv
test/pit_clk_gen.sv
test/pit_props.sv
test/pit_tb.sv
